/* Makefile */
SRCS = design/cheat_pkg.sv design/cheat_regs.sv design/patch_table.sv \
       design/push_detect.sv design/hook_timers.sv design/hook_fsm.sv \
       design/hook_response.sv design/cheat_top.sv \
       verification/cheat_asserts.sv verification/cheat_tb.sv

obj_dir/Vcheat_tb: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module cheat_tb -f compile.f

run: obj_dir/Vcheat_tb
	./obj_dir/Vcheat_tb > sim.log
	cat sim.log
	! grep -q "=== FAIL ===" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* compile.f */
design/cheat_pkg.sv
design/cheat_regs.sv
design/patch_table.sv
design/push_detect.sv
design/hook_timers.sv
design/hook_fsm.sv
design/hook_response.sv
design/cheat_top.sv
verification/cheat_asserts.sv
verification/cheat_tb.sv

/* design/cheat_pkg.sv */
package cheat_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes and vector addresses
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_PATCHES = 6;

  // low byte address with the high byte at +1
  localparam logic [23:0] VEC_NMI = 24'h00FFEA;
  localparam logic [23:0] VEC_IRQ = 24'h00FFEE;
  localparam logic [23:0] VEC_RST = 24'h00FFFC;

  //////////////////////////////////////////////////////////////////////
  // bus and configuration types
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [23:0] addr;
    logic [7:0]  pa;
    logic [7:0]  data;
    logic        wr;
    logic        rd;
    logic        cycle_start;
  } snes_bus_t;

  // bit order follows the flag word of the program port
  typedef struct packed {
    logic savestate_en;
    logic wram_present;
    logic buttons_en;
    logic holdoff_en;
    logic irq_en;
    logic nmi_en;
    logic cheat_en;
  } cheat_cfg_t;

  typedef struct packed {
    logic snescmd;
    logic nmicmd;
    logic return_vector;
    logic branch1;
    logic branch2;
    logic branch3;
  } region_sel_t;

  typedef struct packed {
    logic [23:0] addr;
    logic [7:0]  data;
  } patch_entry_t;

  typedef enum logic [2:0] {
    SLOT_PATCH0 = 3'd0,
    SLOT_PATCH1 = 3'd1,
    SLOT_PATCH2 = 3'd2,
    SLOT_PATCH3 = 3'd3,
    SLOT_PATCH4 = 3'd4,
    SLOT_PATCH5 = 3'd5,
    SLOT_MASK   = 3'd6,
    SLOT_FLAGS  = 3'd7
  } pgm_slot_e;

  typedef enum logic [7:0] {
    CMD_CHEAT_ON  = 8'h82,
    CMD_CHEAT_OFF = 8'h83,
    CMD_HOOKS_OFF = 8'h84,
    CMD_HOLDOFF   = 8'h85
  } snescmd_op_e;

  typedef enum logic [1:0] {
    HOOK_IDLE      = 2'd0,
    HOOK_EXE       = 2'd1,
    HOOK_SNESCMD   = 2'd2,
    HOOK_EXIT_WAIT = 2'd3
  } hook_state_e;

endpackage

/* design/cheat_regs.sv */
`timescale 1ns/100ps

module cheat_regs import cheat_pkg::*; (
  input  logic         clk,
  input  logic         SNES_reset_strobe,
  input  snes_bus_t    bus,
  input  region_sel_t  region,
  input  logic         snescmd_unlock,
  input  logic [2:0]   pgm_idx,
  input  logic         pgm_we,
  input  logic [31:0]  pgm_in,
  output cheat_cfg_t   cfg,
  output patch_entry_t entries [NUM_PATCHES],
  output logic [5:0]   mask,
  output logic [15:0]  pad,
  output logic         holdoff_start,
  output logic         exit_start
);

  cheat_cfg_t cfg_q  = '0;
  logic [5:0] mask_q = '0;
  logic       cmd_wr;
  logic       op_wr;
  pgm_slot_e  slot;

  // handler writes into the command region
  assign cmd_wr = bus.wr & region.snescmd & snescmd_unlock;
  assign op_wr  = cmd_wr & (bus.addr[10:0] == 11'h200);
  assign slot   = pgm_slot_e'(pgm_idx);

  assign holdoff_start = (op_wr & (bus.data == CMD_HOLDOFF))
                       | (SNES_reset_strobe & cfg_q.holdoff_en);
  assign exit_start    = cmd_wr & (bus.addr[10:0] == 11'h3FD);

  // opcodes from the handler take priority over the host
  always_ff @(posedge clk) begin
    if (op_wr) begin
      case (snescmd_op_e'(bus.data))
        CMD_CHEAT_ON:  cfg_q.cheat_en <= 1'b1;
        CMD_CHEAT_OFF: cfg_q.cheat_en <= 1'b0;
        CMD_HOOKS_OFF: begin
          cfg_q.nmi_en <= 1'b0;
          cfg_q.irq_en <= 1'b0;
        end
        default: ;
      endcase
    end else if (pgm_we) begin
      case (slot)
        SLOT_MASK:  mask_q <= pgm_in[5:0];
        // upper byte clears, lower byte sets
        SLOT_FLAGS: cfg_q <= cheat_cfg_t'((cfg_q & ~pgm_in[14:8]) | pgm_in[6:0]);
        default:    entries[pgm_idx] <= patch_entry_t'(pgm_in);
      endcase
    end
  end

  // joypad bytes echoed by the handler
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      pad <= '0;
    end else if (cmd_wr && bus.addr[10:0] == 11'h3F0) begin
      pad[7:0] <= bus.data;
    end else if (cmd_wr && bus.addr[10:0] == 11'h3F1) begin
      pad[15:8] <= bus.data;
    end
  end

  assign cfg  = cfg_q;
  assign mask = mask_q;

endmodule

/* design/cheat_top.sv */
`timescale 1ns/100ps

module cheat_top import cheat_pkg::*; #(
  parameter logic [29:0] HOLDOFF_CYCLES = 30'd960000000,
  parameter logic [6:0]  EXIT_DELAY     = 7'd72
) (
  input  logic        clk,
  input  logic        SNES_reset_strobe,
  input  snes_bus_t   bus,
  input  region_sel_t region,
  input  logic        exe_present,
  input  logic        pad_latch,
  input  logic        snes_ajr,
  input  logic        feat_cmd_unlock_in,
  input  logic [2:0]  pgm_idx,
  input  logic        pgm_we,
  input  logic [31:0] pgm_in,
  output logic [7:0]  data_out,
  output logic        cheat_hit,
  output logic        snescmd_unlock,
  output logic        map_unlock
);

  cheat_cfg_t   cfg;
  patch_entry_t entries [NUM_PATCHES];
  logic [5:0]   mask;
  logic [15:0]  pad;
  logic         holdoff_start;
  logic         exit_start;
  logic         push_cnt_four;
  logic         hook_enable;
  logic         exit_done;
  hook_state_e  state;
  logic         vector_unlock;
  logic         reset_unlock;
  logic         exe_unlock;
  logic [7:0]   return_vector;
  logic         patch_match;
  logic [7:0]   patch_data;

  cheat_regs i_regs (.*);

  patch_table i_patch (
    .bus, .entries, .mask, .cheat_en(cfg.cheat_en), .match(patch_match), .patch_data
  );

  push_detect i_push (.*);

  hook_timers #(
    .HOLDOFF_CYCLES(HOLDOFF_CYCLES),
    .EXIT_DELAY    (EXIT_DELAY)
  ) i_timers (
    .clk, .SNES_reset_strobe, .cycle_start(bus.cycle_start),
    .holdoff_start, .exit_start, .hook_enable, .exit_done
  );

  hook_fsm i_fsm (.*);

  hook_response i_resp (.*);

endmodule

/* design/hook_fsm.sv */
`timescale 1ns/100ps

module hook_fsm import cheat_pkg::*; (
  input  logic        clk,
  input  logic        SNES_reset_strobe,
  input  snes_bus_t   bus,
  input  cheat_cfg_t  cfg,
  input  logic        exe_present,
  input  logic        feat_cmd_unlock_in,
  input  logic        push_cnt_four,
  input  logic        hook_enable,
  input  logic        exit_start,
  input  logic        exit_done,
  output hook_state_e state,
  output logic        vector_unlock,
  output logic        reset_unlock,
  output logic        snescmd_unlock,
  output logic        map_unlock,
  output logic        exe_unlock,
  output logic [7:0]  return_vector
);

  logic       feat_cmd_unlock;
  logic [1:0] vector_cnt;
  logic [1:0] reset_cnt;
  logic       nmi_lo;
  logic       irq_lo;
  logic       rst_lo;
  logic       nmi_trig;
  logic       irq_trig;
  logic       exe_go;
  logic       hook_go;

  always_ff @(posedge clk) begin
    feat_cmd_unlock <= feat_cmd_unlock_in;
  end

  assign nmi_lo = (bus.addr == VEC_NMI);
  assign irq_lo = (bus.addr == VEC_IRQ);
  assign rst_lo = (bus.addr == VEC_RST);

  // vector fetch right after the four stack pushes
  assign nmi_trig = bus.rd & nmi_lo & push_cnt_four & hook_enable;
  assign irq_trig = bus.rd & irq_lo & push_cnt_four & hook_enable;
  // exe only runs from NMI
  assign exe_go   = nmi_trig & exe_present & ~feat_cmd_unlock & (state != HOOK_EXE);
  assign hook_go  = (nmi_trig & cfg.nmi_en) | (irq_trig & cfg.irq_en);

  //////////////////////////////////////////////////////////////////////
  // hook state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      state         <= HOOK_IDLE;
      map_unlock    <= 1'b0;
      return_vector <= 8'hEA;
    end else begin
      case (state)
        HOOK_IDLE, HOOK_SNESCMD: begin
          if (exit_start) begin
            state <= HOOK_EXIT_WAIT;
          end else if (exe_go) begin
            state         <= HOOK_EXE;
            map_unlock    <= 1'b1;
            return_vector <= bus.addr[7:0];
          end else if (hook_go) begin
            state         <= HOOK_SNESCMD;
            return_vector <= bus.addr[7:0];
          end
        end
        HOOK_EXE: begin
          if (exit_start) begin
            state      <= HOOK_EXIT_WAIT;
            map_unlock <= 1'b0;
          end else if (bus.rd && nmi_lo && !push_cnt_four) begin
            // plain NMI fetch leaves the exe while a nested call shows its pushes
            map_unlock <= 1'b0;
            state      <= (hook_enable && cfg.nmi_en) ? HOOK_SNESCMD : HOOK_IDLE;
          end
        end
        HOOK_EXIT_WAIT: begin
          if (exit_done) begin
            state <= HOOK_IDLE;
          end
        end
        default: state <= HOOK_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // vector windows
  //////////////////////////////////////////////////////////////////////

  // patched vector visible for the three reads after the trigger
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      vector_cnt <= '0;
    end else if (exe_go || hook_go) begin
      vector_cnt <= 2'd3;
    end else if (bus.rd && vector_cnt != '0) begin
      vector_cnt <= vector_cnt - 2'd1;
    end
  end

  // first reset fetches only, including a masked read
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      reset_cnt <= 2'd3;
    end else if (bus.cycle_start && rst_lo && reset_cnt != '0) begin
      reset_cnt <= reset_cnt - 2'd1;
    end
  end

  assign vector_unlock  = (vector_cnt != '0);
  assign reset_unlock   = (reset_cnt != '0);
  assign snescmd_unlock = (state != HOOK_IDLE);
  assign exe_unlock     = (state == HOOK_EXE);

endmodule

/* design/hook_response.sv */
`timescale 1ns/100ps

module hook_response import cheat_pkg::*; (
  input  snes_bus_t   bus,
  input  region_sel_t region,
  input  cheat_cfg_t  cfg,
  input  hook_state_e state,
  input  logic [15:0] pad,
  input  logic        patch_match,
  input  logic [7:0]  patch_data,
  input  logic        exe_present,
  input  logic        exe_unlock,
  input  logic        vector_unlock,
  input  logic        reset_unlock,
  input  logic        snescmd_unlock,
  input  logic        map_unlock,
  input  logic        hook_enable,
  input  logic        snes_ajr,
  input  logic        pad_latch,
  input  logic [7:0]  return_vector,
  output logic [7:0]  data_out,
  output logic        cheat_hit
);

  logic [7:0] nmicmd;
  logic [7:0] exit_ofs;
  logic [7:0] branch1_ofs;
  logic [7:0] branch2_ofs;
  logic [7:0] branch3_ofs;
  logic       branch_wram;
  logic       nmi_any;
  logic       irq_any;
  logic       rst_any;
  logic       region_rd;
  logic       hook_active;

  assign nmi_any = (bus.addr == VEC_NMI) | (bus.addr == VEC_NMI + 24'd1);
  assign irq_any = (bus.addr == VEC_IRQ) | (bus.addr == VEC_IRQ + 24'd1);
  assign rst_any = (bus.addr == VEC_RST) | (bus.addr == VEC_RST + 24'd1);
  assign branch_wram = cfg.cheat_en & cfg.wram_present;

  //////////////////////////////////////////////////////////////////////
  // joypad combos and handler branches
  //////////////////////////////////////////////////////////////////////

  // L+R with Start/Select/A/B/X/Y
  always_comb begin
    case (pad)
      16'h3030: nmicmd = 8'h80;
      16'h2070: nmicmd = 8'h81;
      16'h10B0: nmicmd = 8'h82;
      16'h9030: nmicmd = 8'h83;
      16'h5030: nmicmd = 8'h84;
      16'h1070: nmicmd = 8'h85;
      default:  nmicmd = 8'h00;
    endcase
  end

  // patches, then save state, then straight out
  assign exit_ofs = branch_wram ? 8'h3A : (cfg.savestate_en ? 8'h3F : 8'h43);

  always_comb begin
    if (!cfg.buttons_en) begin
      branch1_ofs = exit_ofs;
    end else if (snes_ajr) begin
      branch1_ofs = (nmicmd != 8'h00) ? 8'h30 : exit_ofs;
    end else if (pad_latch) begin
      // game shifts the pad itself and is left alone
      branch1_ofs = branch_wram ? 8'h3A : 8'h43;
    end else begin
      branch1_ofs = 8'h00;
    end
  end

  always_comb begin
    if (nmicmd == 8'h81) begin
      branch2_ofs = 8'h14;
    end else if (branch_wram) begin
      branch2_ofs = 8'h00;
    end else begin
      branch2_ofs = cfg.savestate_en ? 8'h05 : 8'h09;
    end
  end

  assign branch3_ofs = cfg.savestate_en ? 8'h00 : 8'h04;

  //////////////////////////////////////////////////////////////////////
  // read data and hit
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (patch_match) begin
      data_out = patch_data;
    end else if (exe_present && exe_unlock && bus.addr == VEC_NMI) begin
      data_out = 8'h2C;
    end else if (exe_present && exe_unlock && bus.addr == VEC_NMI + 24'd1) begin
      data_out = 8'h00;
    end else if (bus.addr == VEC_NMI || bus.addr == VEC_IRQ) begin
      data_out = 8'h10;
    end else if (bus.addr == VEC_RST) begin
      data_out = 8'h7D;
    end else if (region.nmicmd) begin
      data_out = nmicmd;
    end else if (region.return_vector) begin
      data_out = return_vector;
    end else if (region.branch1) begin
      data_out = branch1_ofs;
    end else if (region.branch2) begin
      data_out = branch2_ofs;
    end else if (region.branch3) begin
      data_out = branch3_ofs;
    end else begin
      data_out = 8'h2A;
    end
  end

  assign region_rd = region.nmicmd | region.return_vector | region.branch1
                   | region.branch2 | region.branch3;
  assign hook_active = (state == HOOK_EXE) | (state == HOOK_SNESCMD);

  assign cheat_hit = patch_match
                   | (reset_unlock & rst_any)
                   | (snescmd_unlock & hook_enable & region_rd)
                   | (hook_enable & hook_active & vector_unlock
                      & ((nmi_any & (cfg.nmi_en | exe_present)) | (irq_any & cfg.irq_en)))
                   // leaving exe also fetches the NMI vector
                   | (hook_enable & map_unlock & nmi_any & cfg.nmi_en);

endmodule

/* design/hook_timers.sv */
`timescale 1ns/100ps

module hook_timers #(
  parameter logic [29:0] HOLDOFF_CYCLES = 30'd960000000,
  parameter logic [6:0]  EXIT_DELAY     = 7'd72
) (
  input  logic clk,
  input  logic SNES_reset_strobe,
  input  logic cycle_start,
  input  logic holdoff_start,
  input  logic exit_start,
  output logic hook_enable,
  output logic exit_done
);

  logic [29:0] holdoff_cnt;
  logic [6:0]  exit_cnt;
  logic        exit_busy;

  // hooks stay blocked while the holdoff count runs
  always_ff @(posedge clk) begin
    if (holdoff_start) begin
      holdoff_cnt <= HOLDOFF_CYCLES;
    end else if (SNES_reset_strobe) begin
      holdoff_cnt <= '0;
    end else if (holdoff_cnt != '0) begin
      holdoff_cnt <= holdoff_cnt - 30'd1;
    end
  end

  assign hook_enable = (holdoff_cnt == '0);

  // time for the handler to leave the command region
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      exit_busy <= 1'b0;
    end else if (exit_start) begin
      exit_busy <= 1'b1;
      exit_cnt  <= EXIT_DELAY;
    end else if (exit_busy && cycle_start) begin
      if (exit_cnt != '0) begin
        exit_cnt <= exit_cnt - 7'd1;
      end else begin
        exit_busy <= 1'b0;
      end
    end
  end

  assign exit_done = exit_busy & cycle_start & (exit_cnt == '0);

endmodule

/* design/patch_table.sv */
`timescale 1ns/100ps

module patch_table import cheat_pkg::*; (
  input  snes_bus_t    bus,
  input  patch_entry_t entries [NUM_PATCHES],
  input  logic [5:0]   mask,
  input  logic         cheat_en,
  output logic         match,
  output logic [7:0]   patch_data
);

  logic [NUM_PATCHES-1:0] hit;

  // one comparator per enabled slot
  always_comb begin
    for (int i = 0; i < NUM_PATCHES; i++) begin
      hit[i] = mask[i] & (bus.addr == entries[i].addr);
    end
  end

  // walk down so the lowest matching slot is taken last
  always_comb begin
    patch_data = 8'h00;
    for (int i = NUM_PATCHES - 1; i >= 0; i--) begin
      if (hit[i]) begin
        patch_data = entries[i].data;
      end
    end
  end

  assign match = cheat_en & (|hit);

endmodule

/* design/push_detect.sv */
`timescale 1ns/100ps

module push_detect import cheat_pkg::*; (
  input  logic      clk,
  input  logic      SNES_reset_strobe,
  input  snes_bus_t bus,
  output logic      push_cnt_four
);

  logic [2:0] push_cnt;
  logic [7:0] next_pa;

  // the CPU pushes PB, PCH, PCL and P to descending stack addresses
  // right before it fetches the vector, seen here on the B-bus mirror
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      push_cnt <= '0;
    end else if (bus.wr) begin
      if (push_cnt == 3'd0) begin
        push_cnt <= 3'd1;
        next_pa  <= bus.pa - 8'd1;
      end else if (bus.pa == next_pa) begin
        push_cnt <= push_cnt + 3'd1;
        next_pa  <= next_pa - 8'd1;
      end else begin
        push_cnt <= '0;
      end
    end else if (bus.rd) begin
      push_cnt <= '0;
    end
  end

  assign push_cnt_four = (push_cnt == 3'd4);

endmodule

/* verification/cheat_asserts.sv */
`timescale 1ns/100ps

module cheat_asserts import cheat_pkg::*; (
  input logic        clk,
  input logic        SNES_reset_strobe,
  input hook_state_e state,
  input logic        map_unlock,
  input logic        snescmd_unlock,
  input logic        vector_unlock,
  input logic        exit_done
);

  // exe mapping only while the exe hook runs
  map_in_exe: assert property (@(posedge clk) disable iff (SNES_reset_strobe)
    map_unlock |-> state == HOOK_EXE)
    else $error("map_unlock high outside HOOK_EXE");

  reset_locks: assert property (@(posedge clk)
    SNES_reset_strobe |=> !snescmd_unlock && !map_unlock && !vector_unlock)
    else $error("unlock output high after reset");

  exit_not_idle: assert property (@(posedge clk) disable iff (SNES_reset_strobe)
    !(exit_done && state == HOOK_IDLE))
    else $error("exit_done while hook FSM idle");

endmodule

bind hook_fsm cheat_asserts i_asserts (
  .clk(clk),
  .SNES_reset_strobe(SNES_reset_strobe),
  .state(state),
  .map_unlock(map_unlock),
  .snescmd_unlock(snescmd_unlock),
  .vector_unlock(vector_unlock),
  .exit_done(exit_done)
);

/* verification/cheat_tb.sv */
`timescale 1ns/100ps

module cheat_tb import cheat_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam region_sel_t NO_REGION = '0;

  // flag word bits in cheat_cfg_t order
  localparam logic [6:0] FLAG_CHEAT     = 7'h01;
  localparam logic [6:0] FLAG_NMI       = 7'h02;
  localparam logic [6:0] FLAG_SAVESTATE = 7'h40;

  logic        clk;
  logic        SNES_reset_strobe;
  snes_bus_t   bus;
  region_sel_t region;
  logic        exe_present;
  logic        pad_latch;
  logic        snes_ajr;
  logic        feat_cmd_unlock_in;
  logic [2:0]  pgm_idx;
  logic        pgm_we;
  logic [31:0] pgm_in;
  logic [7:0]  data_out;
  logic        cheat_hit;
  logic        snescmd_unlock;
  logic        map_unlock;

  logic [7:0]  rd_data;
  logic        rd_hit;
  int          errors = 0;
  int          checks = 0;
  int          clk_count = 0;

  cheat_top #(
    .HOLDOFF_CYCLES(30'd200)
  ) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    clk_count <= clk_count + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // bus and host helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%s: %s (%0d errors)", name, (errors == errs_before) ? "ok" : "failed",
             errors - errs_before);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    SNES_reset_strobe = 1'b1;
    repeat (16) @(negedge clk);
    SNES_reset_strobe = 1'b0;
  endtask

  // one bus cycle with outputs sampled a quarter period after the drive
  task automatic bus_cycle(input logic [23:0] addr, input logic [7:0] pa,
                           input logic [7:0] wdata, input logic wr, input logic rd,
                           input region_sel_t r);
    @(negedge clk);
    bus.addr        = addr;
    bus.pa          = pa;
    bus.data        = wdata;
    bus.wr          = wr;
    bus.rd          = rd;
    bus.cycle_start = 1'b1;
    region          = r;
    #(CLK_PERIOD / 4);
    rd_data = data_out;
    rd_hit  = cheat_hit;
    @(negedge clk);
    bus    = '0;
    region = '0;
  endtask

  task automatic bus_read(input logic [23:0] addr, input region_sel_t r);
    bus_cycle(addr, 8'h00, 8'h00, 1'b0, 1'b1, r);
  endtask

  // handler write into the command region
  task automatic cmd_write(input logic [10:0] ofs, input logic [7:0] value);
    region_sel_t r;
    r = NO_REGION;
    r.snescmd = 1'b1;
    bus_cycle(24'h002800 | {13'd0, ofs}, 8'h00, value, 1'b1, 1'b0, r);
  endtask

  // four stack pushes then the NMI vector fetch
  task automatic trigger_nmi();
    for (int i = 0; i < 4; i++) begin
      bus_cycle(24'h0001FF - 24'(i), 8'hFF - 8'(i), 8'h00, 1'b1, 1'b0, NO_REGION);
    end
    bus_read(VEC_NMI, NO_REGION);
  endtask

  task automatic host_write(input logic [2:0] idx, input logic [31:0] value);
    @(negedge clk);
    pgm_idx = idx;
    pgm_in  = value;
    pgm_we  = 1'b1;
    @(negedge clk);
    pgm_we  = 1'b0;
  endtask

  task automatic set_flags(input logic [6:0] set_bits, input logic [6:0] clr_bits);
    host_write(SLOT_FLAGS, {16'd0, 1'b0, clr_bits, 1'b0, set_bits});
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_vector();
    int errs;
    errs = errors;
    for (int i = 0; i < 3; i++) begin
      bus_read(VEC_RST, NO_REGION);
      check(32'(rd_data), 'h7D, "reset vector low byte");
      check(32'(rd_hit), 1, "reset vector hit in window");
    end
    bus_read(VEC_RST, NO_REGION);
    check(32'(rd_hit), 0, "reset vector hit after window");
    report_test("reset vector", errs);
  endtask

  task automatic test_patches();
    int          errs;
    logic [23:0] p_addr [NUM_PATCHES];
    logic [7:0]  p_data [NUM_PATCHES];
    errs = errors;
    for (int i = 0; i < NUM_PATCHES; i++) begin
      p_addr[i] = {4'h4, 4'(i), 16'($urandom)};
      p_data[i] = 8'($urandom);
    end
    // slot 5 shadows slot 2
    p_addr[5] = p_addr[2];
    p_data[5] = ~p_data[2];
    for (int i = 0; i < NUM_PATCHES; i++) begin
      host_write(3'(i), {p_addr[i], p_data[i]});
    end
    host_write(SLOT_MASK, 32'h0000_002F);
    set_flags(FLAG_CHEAT | FLAG_NMI, 7'h00);
    for (int i = 0; i < 4; i++) begin
      bus_read(p_addr[i], NO_REGION);
      check(32'(rd_data), 32'(p_data[i]), "patch data");
      check(32'(rd_hit), 1, "patch hit");
    end
    bus_read(p_addr[4], NO_REGION);
    check(32'(rd_hit), 0, "masked slot hit");
    bus_read(p_addr[5], NO_REGION);
    check(32'(rd_data), 32'(p_data[2]), "lower slot wins on shared address");
    trigger_nmi();
    check(32'(snescmd_unlock), 1, "unlock before cheat off");
    cmd_write(11'h200, CMD_CHEAT_OFF);
    for (int i = 0; i < 4; i++) begin
      bus_read(p_addr[i], NO_REGION);
      check(32'(rd_hit), 0, "patch hit after cheat off");
    end
    report_test("patches", errs);
  endtask

  task automatic test_nmi_hook();
    int          errs;
    region_sel_t r;
    errs = errors;
    bus_read(VEC_NMI, NO_REGION);
    check(32'(snescmd_unlock), 0, "unlock without stack pushes");
    trigger_nmi();
    check(32'(rd_data), 'h10, "nmi vector low byte");
    check(32'(snescmd_unlock), 1, "unlock after nmi trigger");
    bus_read(VEC_NMI + 24'd1, NO_REGION);
    check(32'(rd_hit), 1, "nmi vector high byte hit");
    bus_read(VEC_NMI, NO_REGION);
    check(32'(rd_data), 'h10, "nmi vector reread");
    check(32'(rd_hit), 1, "nmi vector reread hit");
    r = NO_REGION;
    r.return_vector = 1'b1;
    bus_read(24'h002A40, r);
    check(32'(rd_data), 'hEA, "return vector");
    check(32'(rd_hit), 1, "return vector hit");
    report_test("nmi hook", errs);
  endtask

  task automatic test_exit_holdoff();
    int errs;
    int pulses;
    int t_hold;
    errs = errors;
    trigger_nmi();
    check(32'(snescmd_unlock), 1, "unlock before holdoff");
    cmd_write(11'h200, CMD_HOLDOFF);
    t_hold = clk_count;
    cmd_write(11'h3FD, 8'h00);
    pulses = 0;
    while (snescmd_unlock && pulses < 100) begin
      bus_cycle(24'h7E0000, 8'h00, 8'h00, 1'b0, 1'b0, NO_REGION);
      pulses++;
    end
    if (snescmd_unlock) begin
      errors++;
      $display("timeout: command region still unlocked after %0d cycle_starts", pulses);
    end
    check(32'(pulses >= 72 && pulses <= 74), 1, "exit delay in cycle_starts");
    // still inside the 200 clock holdoff
    trigger_nmi();
    check(32'(snescmd_unlock), 0, "trigger during holdoff");
    while (clk_count - t_hold < 210) begin
      @(negedge clk);
    end
    trigger_nmi();
    check(32'(snescmd_unlock), 1, "trigger after holdoff");
    report_test("exit and holdoff", errs);
  endtask

  task automatic test_exe_path();
    int errs;
    errs = errors;
    @(negedge clk);
    exe_present = 1'b1;
    trigger_nmi();
    check(32'(map_unlock), 1, "map unlock after exe trigger");
    bus_read(VEC_NMI + 24'd1, NO_REGION);
    check(32'(rd_data), 'h00, "exe vector high byte");
    check(32'(rd_hit), 1, "exe vector high byte hit");
    check(32'(map_unlock), 1, "map unlock held");
    // plain NMI fetch leaves the exe
    bus_read(VEC_NMI, NO_REGION);
    check(32'(rd_data), 'h2C, "exe vector low byte");
    check(32'(rd_hit), 1, "exe vector low byte hit");
    check(32'(map_unlock), 0, "map unlock after plain nmi read");
    @(negedge clk);
    exe_present = 1'b0;
    report_test("exe path", errs);
  endtask

  task automatic test_pad_commands();
    int          errs;
    region_sel_t r;
    errs = errors;
    trigger_nmi();
    cmd_write(11'h3F0, 8'h30);
    cmd_write(11'h3F1, 8'h30);
    r = NO_REGION;
    r.nmicmd = 1'b1;
    bus_read(24'h002A60, r);
    check(32'(rd_data), 'h80, "nmicmd for pad 3030");
    check(32'(rd_hit), 1, "nmicmd region hit");
    cmd_write(11'h3F0, 8'h70);
    cmd_write(11'h3F1, 8'h20);
    r = NO_REGION;
    r.branch2 = 1'b1;
    bus_read(24'h002A64, r);
    check(32'(rd_data), 'h14, "branch2 for pad 2070");
    r = NO_REGION;
    r.branch3 = 1'b1;
    set_flags(FLAG_SAVESTATE, 7'h00);
    bus_read(24'h002A68, r);
    check(32'(rd_data), 'h00, "branch3 with save states");
    set_flags(7'h00, FLAG_SAVESTATE);
    bus_read(24'h002A68, r);
    check(32'(rd_data), 'h04, "branch3 without save states");
    report_test("pad commands", errs);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(92));
    SNES_reset_strobe  = 1'b1;
    bus                = '0;
    region             = '0;
    exe_present        = 1'b0;
    pad_latch          = 1'b0;
    snes_ajr           = 1'b0;
    feat_cmd_unlock_in = 1'b0;
    pgm_idx            = '0;
    pgm_we             = 1'b0;
    pgm_in             = '0;
    apply_reset();
    test_reset_vector();
    test_patches();
    apply_reset();
    test_nmi_hook();
    apply_reset();
    test_exit_holdoff();
    apply_reset();
    test_exe_path();
    apply_reset();
    test_pad_commands();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
